// ==== design/bit_fifo.sv ====
`default_nettype none

`include "bitpack_defines.svh"

module bit_fifo (
   input  wire                  clk_i,
   input  wire                  rst_n_i,

   input  wire                  write_i,
   input  bitpack_pkg::cwidth_t wwidth_i,
   input  bitpack_pkg::code_t   wdata_i,
   output bitpack_pkg::level_t  wlevel_o,

   input  wire                  read_i,
   input  bitpack_pkg::cwidth_t rwidth_i,
   output bitpack_pkg::byte_t   rdata_o,
   output bitpack_pkg::level_t  rlevel_o
);

   localparam bitpack_pkg::level_t FULL_LEVEL = bitpack_pkg::level_t'(`BP_REG_W);
   localparam int PAD_W = `BP_REG_W - `BP_CODE_W;

   // valid bits sit at the top, msb is the oldest
   logic [`BP_REG_W-1:0] data_q;
   logic [`BP_REG_W-1:0] data_d;
   bitpack_pkg::level_t  rlevel_q;
   bitpack_pkg::level_t  rlevel_d;

   bitpack_pkg::code_t   wmask;
   bitpack_pkg::code_t   wdata_m;
   logic [`BP_REG_W-1:0] wplace;
   bitpack_pkg::byte_t   rmask;

   // keep only the top wwidth bits of the incoming code
   assign wmask   = ~({`BP_CODE_W{1'b1}} >> wwidth_i);
   assign wdata_m = wdata_i & wmask;

   // code lands right below the bits already stored
   assign wplace  = {wdata_m, {PAD_W{1'b0}}} >> rlevel_q;

   // top rwidth bits of the register, rest zero
   assign rmask   = ~({`BP_BYTE_W{1'b1}} >> rwidth_i);
   assign rdata_o = data_q[`BP_REG_W-1 -: `BP_BYTE_W] & rmask;

   assign rlevel_o = rlevel_q;
   assign wlevel_o = FULL_LEVEL - rlevel_q;

   always_comb begin
      data_d   = data_q;
      rlevel_d = rlevel_q;

      // write wins, a read in the same cycle is dropped
      if (write_i) begin
         data_d   = data_q | wplace;
         rlevel_d = rlevel_q + bitpack_pkg::level_t'(wwidth_i);
      end else if (read_i) begin
         data_d   = data_q << rwidth_i;
         rlevel_d = rlevel_q - bitpack_pkg::level_t'(rwidth_i);
      end
   end

   // bits below the fill must stay zero for the OR merge
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         data_q   <= '0;
         rlevel_q <= '0;
      end else begin
         data_q   <= data_d;
         rlevel_q <= rlevel_d;
      end
   end

endmodule

`default_nettype wire

// ==== design/bitpack_defines.svh ====
`ifndef BITPACK_DEFINES_SVH
`define BITPACK_DEFINES_SVH

// bit fifo register width
`define BP_REG_W 32

// widest code accepted at the input
`define BP_CODE_W 16

// output byte width
`define BP_BYTE_W 8

// code queue entries
`define BP_QUEUE_DEPTH 4

// level value, holds 0 to BP_REG_W
`define BP_LEVEL_W 6

// code width field, holds 0 to BP_CODE_W
`define BP_CWIDTH_W 5

`endif

// ==== design/bitpack_pkg.sv ====
`default_nettype none

`include "bitpack_defines.svh"

package bitpack_pkg;

   // fill level of the bit fifo, 0 to 32
   typedef logic [`BP_LEVEL_W-1:0] level_t;

   // code width, 0 to 16
   typedef logic [`BP_CWIDTH_W-1:0] cwidth_t;

   // code bits, left-justified
   typedef logic [`BP_CODE_W-1:0] code_t;

   typedef logic [`BP_BYTE_W-1:0] byte_t;

   // writer sequencing
   typedef enum logic [1:0] {
      WR_CODES,
      WR_PAD,
      WR_WAIT
   } wr_state_e;

   // reader sequencing
   typedef enum logic {
      RD_RUN,
      RD_FLUSH
   } rd_state_e;

endpackage

`default_nettype wire

// ==== design/bitpack_top.sv ====
`default_nettype none

`include "bitpack_defines.svh"

module bitpack_top (
   input  wire                  clk_i,
   input  wire                  rst_n_i,

   input  wire                  code_valid_i,
   input  bitpack_pkg::cwidth_t code_width_i,
   input  bitpack_pkg::code_t   code_bits_i,
   input  wire                  flush_i,
   output logic                 full_o,

   output logic                 byte_valid_o,
   output bitpack_pkg::byte_t   byte_o,
   output logic                 flush_done_o
);

   // reader always takes whole bytes
   localparam bitpack_pkg::cwidth_t READ_WIDTH = bitpack_pkg::cwidth_t'(`BP_BYTE_W);

   logic                 fifo_write;
   bitpack_pkg::cwidth_t fifo_wwidth;
   bitpack_pkg::code_t   fifo_wdata;
   bitpack_pkg::level_t  fifo_wlevel;
   logic                 fifo_read;
   bitpack_pkg::byte_t   fifo_rdata;
   bitpack_pkg::level_t  fifo_rlevel;
   logic                 pad_done;
   logic                 flush_done;

   assign flush_done_o = flush_done;

   code_writer u_writer (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .code_valid_i  (code_valid_i),
      .code_width_i  (code_width_i),
      .code_bits_i   (code_bits_i),
      .flush_i       (flush_i),
      .flush_done_i  (flush_done),
      .full_o        (full_o),
      .fifo_wlevel_i (fifo_wlevel),
      .fifo_write_o  (fifo_write),
      .fifo_wwidth_o (fifo_wwidth),
      .fifo_wdata_o  (fifo_wdata),
      .pad_done_o    (pad_done)
   );

   bit_fifo u_fifo (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .write_i  (fifo_write),
      .wwidth_i (fifo_wwidth),
      .wdata_i  (fifo_wdata),
      .wlevel_o (fifo_wlevel),
      .read_i   (fifo_read),
      .rwidth_i (READ_WIDTH),
      .rdata_o  (fifo_rdata),
      .rlevel_o (fifo_rlevel)
   );

   byte_reader u_reader (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .fifo_rlevel_i (fifo_rlevel),
      .fifo_rdata_i  (fifo_rdata),
      .fifo_write_i  (fifo_write),
      .fifo_read_o   (fifo_read),
      .pad_done_i    (pad_done),
      .byte_valid_o  (byte_valid_o),
      .byte_o        (byte_o),
      .flush_done_o  (flush_done)
   );

endmodule

`default_nettype wire

// ==== design/byte_reader.sv ====
`default_nettype none

`include "bitpack_defines.svh"

module byte_reader (
   input  wire                  clk_i,
   input  wire                  rst_n_i,

   // read side of the bit fifo
   input  bitpack_pkg::level_t  fifo_rlevel_i,
   input  bitpack_pkg::byte_t   fifo_rdata_i,
   input  wire                  fifo_write_i,
   output logic                 fifo_read_o,

   // flush sequencing
   input  wire                  pad_done_i,

   // byte output
   output logic                 byte_valid_o,
   output bitpack_pkg::byte_t   byte_o,
   output logic                 flush_done_o
);

   localparam bitpack_pkg::level_t BYTE_LEVEL = bitpack_pkg::level_t'(`BP_BYTE_W);

   bitpack_pkg::rd_state_e state;
   logic                   fifo_empty;

   // the fifo drops a read in a write cycle, so hold off then
   assign fifo_read_o = (fifo_rlevel_i >= BYTE_LEVEL) && !fifo_write_i;
   assign fifo_empty  = (fifo_rlevel_i == '0);

   always_ff @(posedge clk_i) begin
      if (fifo_read_o) begin
         byte_o <= fifo_rdata_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state        <= bitpack_pkg::RD_RUN;
         byte_valid_o <= 1'b0;
         flush_done_o <= 1'b0;
      end else begin
         byte_valid_o <= fifo_read_o;
         flush_done_o <= 1'b0;
         case (state)
            bitpack_pkg::RD_RUN: begin
               if (pad_done_i) begin
                  state <= bitpack_pkg::RD_FLUSH;
               end
            end
            bitpack_pkg::RD_FLUSH: begin
               // last byte must be out before done
               if (fifo_empty && !byte_valid_o) begin
                  flush_done_o <= 1'b1;
                  state        <= bitpack_pkg::RD_RUN;
               end
            end
            default: begin
               state <= bitpack_pkg::RD_RUN;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/code_writer.sv ====
`default_nettype none

`include "bitpack_defines.svh"

module code_writer (
   input  wire                   clk_i,
   input  wire                   rst_n_i,

   // code input
   input  wire                   code_valid_i,
   input  bitpack_pkg::cwidth_t  code_width_i,
   input  bitpack_pkg::code_t    code_bits_i,
   input  wire                   flush_i,
   input  wire                   flush_done_i,
   output logic                  full_o,

   // write side of the bit fifo
   input  bitpack_pkg::level_t   fifo_wlevel_i,
   output logic                  fifo_write_o,
   output bitpack_pkg::cwidth_t  fifo_wwidth_o,
   output bitpack_pkg::code_t    fifo_wdata_o,
   output logic                  pad_done_o
);

   localparam int QPTR_W     = $clog2(`BP_QUEUE_DEPTH);
   localparam int BYTE_IDX_W = $clog2(`BP_BYTE_W);

   localparam logic [QPTR_W-1:0] LAST_PTR   = QPTR_W'(`BP_QUEUE_DEPTH - 1);
   localparam logic [QPTR_W:0]   QUEUE_FULL = (QPTR_W + 1)'(`BP_QUEUE_DEPTH);

   // queue storage
   bitpack_pkg::cwidth_t q_width [`BP_QUEUE_DEPTH];
   bitpack_pkg::code_t   q_code  [`BP_QUEUE_DEPTH];

   logic [QPTR_W-1:0]     wr_ptr;
   logic [QPTR_W-1:0]     rd_ptr;
   logic [QPTR_W:0]       count;
   logic                  flush_pend;
   bitpack_pkg::wr_state_e state;

   logic                  push;
   logic                  pop;
   logic                  flush_take;
   logic                  in_pad;
   bitpack_pkg::cwidth_t  head_width;
   bitpack_pkg::cwidth_t  pad_width;

   assign full_o     = (count == QUEUE_FULL) || flush_pend;
   assign push       = code_valid_i && !full_o;
   assign flush_take = flush_i && !flush_pend;

   assign head_width = q_width[rd_ptr];
   assign in_pad     = (state == bitpack_pkg::WR_PAD);

   // head leaves the queue once it fits in the free space
   assign pop = (state == bitpack_pkg::WR_CODES) && (count != '0) &&
                (bitpack_pkg::level_t'(head_width) <= fifo_wlevel_i);

   // free space mod 8 is the distance to the next byte boundary
   assign pad_width = bitpack_pkg::cwidth_t'(fifo_wlevel_i[BYTE_IDX_W-1:0]);

   // zero-width codes and empty pads retire without a fifo write
   assign fifo_write_o  = (pop && (head_width != '0)) || (in_pad && (pad_width != '0));
   assign fifo_wwidth_o = in_pad ? pad_width : head_width;
   assign fifo_wdata_o  = in_pad ? '0 : q_code[rd_ptr];
   assign pad_done_o    = in_pad;

   always_ff @(posedge clk_i) begin
      if (push) begin
         q_width[wr_ptr] <= code_width_i;
         q_code[wr_ptr]  <= code_bits_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // a code taken together with the flush goes out ahead of the pad
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state      <= bitpack_pkg::WR_CODES;
         flush_pend <= 1'b0;
      end else begin
         if (flush_take) begin
            flush_pend <= 1'b1;
         end
         case (state)
            bitpack_pkg::WR_CODES: begin
               if (flush_pend && (count == '0)) begin
                  state <= bitpack_pkg::WR_PAD;
               end
            end
            bitpack_pkg::WR_PAD: begin
               state <= bitpack_pkg::WR_WAIT;
            end
            bitpack_pkg::WR_WAIT: begin
               // reader has emptied the fifo
               if (flush_done_i) begin
                  state      <= bitpack_pkg::WR_CODES;
                  flush_pend <= 1'b0;
               end
            end
            default: begin
               state <= bitpack_pkg::WR_CODES;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module bitpack_tb \
   -f verilog.f -Mdir obj_dir

out=$(./obj_dir/Vbitpack_tb) || { echo "$out"; echo "simulation exited with an error"; exit 1; }
echo "$out"

if echo "$out" | grep -qF '** PASS **'; then
   exit 0
fi
exit 1

// ==== verification/bitpack_clkgen.sv ====
`default_nettype none

module bitpack_clkgen #(
   parameter int PERIOD = 8
) (
   output logic clk_o
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD / 2) clk_o = ~clk_o;
      end
   end

endmodule

`default_nettype wire

// ==== verification/bitpack_properties.sv ====
`default_nettype none

module bitpack_properties (
   input wire clk_i,
   input wire rst_n_i,
   input wire code_valid_i,
   input wire full_i,
   input wire byte_valid_i,
   input wire flush_done_i
);

   timeunit 1ns;
   timeprecision 100ps;

   // output register clears on the first reset edge
   a_no_byte_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !byte_valid_i)
      else $error("byte_valid_o high during reset");

   // a strobe while full would lose the code
   a_no_code_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      code_valid_i |-> !full_i)
      else $error("code strobed while full_o is high");

   a_flush_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      flush_done_i |=> !flush_done_i)
      else $error("flush_done_o high for more than one cycle");

endmodule

bind bitpack_top bitpack_properties u_props (
   .clk_i        (clk_i),
   .rst_n_i      (rst_n_i),
   .code_valid_i (code_valid_i),
   .full_i       (full_o),
   .byte_valid_i (byte_valid_o),
   .flush_done_i (flush_done_o)
);

`default_nettype wire

// ==== verification/bitpack_tb.sv ====
`default_nettype none

`include "bitpack_defines.svh"

module bitpack_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_ALIGNED   = 8;
   localparam int N_RANDOM    = 200;
   localparam int N_FLUSH     = 4;
   localparam int N_BURST     = 40;
   localparam int TOTAL_CODES = N_ALIGNED + N_RANDOM + N_FLUSH + N_BURST;
   localparam int WAIT_LIMIT  = 200;

   wire                  clk;
   logic                 rst_n;
   logic                 code_valid;
   bitpack_pkg::cwidth_t code_width;
   bitpack_pkg::code_t   code_bits;
   logic                 flush;
   logic                 full_out;
   logic                 byte_valid;
   bitpack_pkg::byte_t   byte_out;
   logic                 flush_done_out;

   integer               seed;
   logic                 exp_bits[$];
   bitpack_pkg::byte_t   exp_bytes[$];
   int                   errors;
   int                   checks;
   int                   start_errors;
   int                   bytes_seen;
   int                   flush_done_seen;
   int                   full_cycles;

   bitpack_clkgen #(.PERIOD(8)) u_clkgen (.clk_o(clk));

   bitpack_top u_dut (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .code_valid_i (code_valid),
      .code_width_i (code_width),
      .code_bits_i  (code_bits),
      .flush_i      (flush),
      .full_o       (full_out),
      .byte_valid_o (byte_valid),
      .byte_o       (byte_out),
      .flush_done_o (flush_done_out)
   );

   // full bytes leave the bit queue msb first
   function automatic void move_bytes();
      bitpack_pkg::byte_t b;
      int j;
      while (exp_bits.size() >= `BP_BYTE_W) begin
         b = '0;
         for (j = 0; j < `BP_BYTE_W; j++) begin
            b = {b[`BP_BYTE_W-2:0], exp_bits.pop_front()};
         end
         exp_bytes.push_back(b);
      end
   endfunction

   // reference packer takes the top width bits of a left-justified code
   function automatic void pack_code(input int width, input bitpack_pkg::code_t bits);
      int i;
      for (i = 0; i < width; i++) begin
         exp_bits.push_back(bits[`BP_CODE_W-1-i]);
      end
      move_bytes();
   endfunction

   function automatic void pad_to_byte();
      while ((exp_bits.size() % `BP_BYTE_W) != 0) begin
         exp_bits.push_back(1'b0);
      end
      move_bytes();
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic end_test(input int num, input string name);
      $display("test %0d %s done, %0d errors", num, name, errors - start_errors);
      start_errors = errors;
   endtask

   // called and returns 1 ns after an edge
   task automatic send_code(input int width, input bitpack_pkg::code_t bits);
      int waited;
      waited = 0;
      while (full_out && waited < WAIT_LIMIT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (full_out) begin
         errors++;
         $display("full_o stayed high for %0d cycles, code not sent", WAIT_LIMIT);
      end else begin
         code_valid = 1'b1;
         code_width = bitpack_pkg::cwidth_t'(width);
         code_bits  = bits;
         pack_code(width, bits);
         @(posedge clk);
         #1;
         code_valid = 1'b0;
      end
   endtask

   task automatic do_flush();
      int start;
      int waited;
      start = flush_done_seen;
      waited = 0;
      pad_to_byte();
      flush = 1'b1;
      @(posedge clk);
      #1;
      flush = 1'b0;
      while (flush_done_seen == start && waited < WAIT_LIMIT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (flush_done_seen == start) begin
         errors++;
         $display("no flush_done_o pulse within %0d cycles of the flush", WAIT_LIMIT);
      end
      // room for a stray second pulse
      repeat (4) @(posedge clk);
      #1;
      check_value("flush_done_o pulses", 32'(flush_done_seen - start), 1);
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_bytes.size() != 0 && waited < WAIT_LIMIT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (exp_bytes.size() != 0) begin
         errors++;
         $display("%0d expected bytes never came out", exp_bytes.size());
      end
   endtask

   // sample on the falling edge clear of the register updates
   always @(negedge clk) begin
      if (rst_n) begin
         if (byte_valid) begin
            bytes_seen++;
            if (exp_bytes.size() == 0) begin
               errors++;
               $display("byte %0h came out at %0d ns with none expected", byte_out, $time);
            end else begin
               check_value("byte_o", 32'(byte_out), 32'(exp_bytes.pop_front()));
            end
         end
         if (flush_done_out) begin
            flush_done_seen++;
            check_value("bytes still due at flush_done_o", 32'(exp_bytes.size()), 0);
         end
         if (full_out) begin
            full_cycles++;
         end
      end
   end

   initial begin
      repeat (TOTAL_CODES * 40 + 500) @(posedge clk);
      $display("watchdog expired after %0d cycles, run did not finish", TOTAL_CODES * 40 + 500);
      $display("** FAIL **");
      $finish;
   end

   initial begin
      int i;
      int r;
      int bytes_before;
      int full_before;
      seed            = 16;
      rst_n           = 1'b0;
      code_valid      = 1'b0;
      code_width      = '0;
      code_bits       = '0;
      flush           = 1'b0;
      errors          = 0;
      checks          = 0;
      start_errors    = 0;
      bytes_seen      = 0;
      flush_done_seen = 0;
      full_cycles     = 0;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;

      repeat (20) begin
         @(negedge clk);
         check_value("full_o", 32'(full_out), 0);
         check_value("byte_valid_o", 32'(byte_valid), 0);
         check_value("flush_done_o", 32'(flush_done_out), 0);
      end
      @(posedge clk);
      #1;
      end_test(1, "idle after reset");

      // low byte set to check the input masking
      for (i = 0; i < N_ALIGNED; i++) begin
         send_code(8, {8'(i * 29 + 60), 8'hff});
      end
      wait_drain();
      end_test(2, "byte codes");

      for (i = 0; i < N_RANDOM; i++) begin
         r = $random(seed);
         send_code(1 + (r & 15), 16'($random(seed)));
         if (r[8]) begin
            @(posedge clk);
            #1;
         end
      end
      do_flush();
      end_test(3, "random widths");

      // 5 + 0 + 6 bits leave a 3-bit tail
      bytes_before = bytes_seen;
      send_code(5, 16'hb800);
      send_code(0, 16'hffff);
      send_code(6, 16'h6400);
      do_flush();
      check_value("bytes from unaligned flush", 32'(bytes_seen - bytes_before), 2);
      bytes_before = bytes_seen;
      send_code(16, 16'hc3a5);
      do_flush();
      check_value("bytes from aligned flush", 32'(bytes_seen - bytes_before), 2);
      end_test(4, "flush");

      full_before = full_cycles;
      for (i = 0; i < N_BURST; i++) begin
         send_code(16, 16'($random(seed)));
      end
      wait_drain();
      check_value("full_o seen in burst", 32'(full_cycles > full_before), 1);
      check_value("full_o after drain", 32'(full_out), 0);
      end_test(5, "back-pressure");

      $display("tests 5, checks %0d, errors %0d, bytes %0d", checks, errors, bytes_seen);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
design/bitpack_pkg.sv
design/bit_fifo.sv
design/code_writer.sv
design/byte_reader.sv
design/bitpack_top.sv
verification/bitpack_clkgen.sv
verification/bitpack_properties.sv
verification/bitpack_tb.sv
